// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Memory depths as word address widths
`define CPU_IM_AW 8
`define CPU_DM_AW 8

// Major opcodes, bits 30:25
`define CPU_OP_ALU  6'h20
`define CPU_OP_ADDI 6'h28
`define CPU_OP_ORI  6'h2c
`define CPU_OP_LSW  6'h1c
`define CPU_OP_J    6'h24
`define CPU_OP_JAL  6'h25

// Register op selection
`define CPU_SUB_ADD 5'h00
`define CPU_SUB_SUB 5'h01
`define CPU_SUB_AND 5'h02
`define CPU_SUB_OR  5'h04
`define CPU_SUB_XOR 5'h03

`define CPU_LS_LW 8'h02
`define CPU_LS_SW 8'h0a

// Write-back source
`define CPU_WB_ALU  2'd0
`define CPU_WB_MEM  2'd1
`define CPU_WB_LINK 2'd2

`define CPU_LINK_REG 5'd31

`endif

// File: rtl/cpu_pkg.sv
package cpu_pkg;

	typedef struct packed {
		logic       spare;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] spare_lo;
		logic [4:0] sub_op_base;
	} instr_reg_t;

	typedef struct packed {
		logic        spare;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic        spare_lo;
		logic [13:0] imm14;
	} instr_imm_t;

	// Low byte of the offset shares its bits with sub_op_ls
	typedef struct packed {
		logic       spare;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [6:0] spare_lo;
		logic [7:0] sub_op_ls;
	} instr_ls_t;

	typedef struct packed {
		logic        spare;
		logic [5:0]  opcode;
		logic        spare_lo;
		logic [23:0] imm24;
	} instr_jump_t;

	typedef union packed {
		instr_reg_t  r;
		instr_imm_t  i;
		instr_ls_t   ls;
		instr_jump_t j;
	} instr_u;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] ra_data;
		logic [31:0] rt_data;
		logic [5:0]  opcode;
		logic [4:0]  sub_op_base;
		logic [7:0]  sub_op_ls;
		logic [13:0] imm14;
		logic [23:0] imm24;
		logic [4:0]  write_reg;
		logic [1:0]  select_write_reg;
		logic        do_dm_read;
		logic        do_dm_write;
		logic        do_reg_write;
		logic [31:0] alu_src2;
		logic [31:0] link;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_result;
		logic        alu_overflow;
		logic [31:0] store_data;
		logic [4:0]  write_reg;
		logic [1:0]  select_write_reg;
		logic        do_dm_read;
		logic        do_dm_write;
		logic        do_reg_write;
		logic [31:0] link;
	} ex_mem_t;

	typedef struct packed {
		logic [31:0] write_reg_data;
		logic [4:0]  write_reg;
		logic        do_reg_write;
		logic        overflow;
	} mem_wb_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  reg_num;
		logic [31:0] data;
		logic        overflow;
	} wb_event_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] address;
		logic [31:0] data;
	} store_event_t;

endpackage

// File: rtl/fetch_unit.sv
`include "cpu_consts.svh"

module fetch_unit (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic [`CPU_IM_AW-1:0] load_addr,
	input  logic [31:0]           load_data,
	input  logic                  jump_taken,
	input  logic [23:0]           jump_target,
	output cpu_pkg::if_id_t       fetch
);
	import cpu_pkg::*;

	logic [31:0] imem [0:(1 << `CPU_IM_AW) - 1];
	logic [31:0] pc;

	// Loader port writes only while reset holds the core
	always_ff @(posedge clock) begin
		if (rst && load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= 32'd0;
		end else if (jump_taken) begin
			pc <= {8'd0, jump_target}; // Absolute word target
		end else begin
			pc <= pc + 32'd1;
		end
	end

	always_comb begin
		fetch.valid = !rst;
		fetch.pc    = pc;
		fetch.instr = imem[pc[`CPU_IM_AW-1:0]];
	end

endmodule

// File: rtl/decode_ctrl.sv
`include "cpu_consts.svh"

module decode_ctrl (
	input  cpu_pkg::if_id_t fetched,
	input  logic [31:0]     ra_data,
	input  logic [31:0]     rt_data,
	output logic [4:0]      ra_addr,
	output logic [4:0]      rt_addr,
	output cpu_pkg::id_ex_t decoded,
	output logic            jump_taken,
	output logic [23:0]     jump_target
);
	import cpu_pkg::*;

	instr_u      word;
	logic [5:0]  opcode;
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;
	logic        writes_reg;

	assign word     = fetched.instr;
	assign opcode   = word.r.opcode;
	assign imm_sext = {{18{word.i.imm14[13]}}, word.i.imm14};
	assign imm_zext = {18'd0, word.i.imm14};

	// Second port reads rb for register ops, rt otherwise (store data)
	assign ra_addr = word.r.ra;
	assign rt_addr = (opcode == `CPU_OP_ALU) ? word.r.rb : word.r.rt;

	assign jump_taken  = fetched.valid && (opcode == `CPU_OP_J || opcode == `CPU_OP_JAL);
	assign jump_target = word.j.imm24;

	always_comb begin
		writes_reg               = 1'b0;
		decoded.valid            = fetched.valid;
		decoded.ra_data          = ra_data;
		decoded.rt_data          = rt_data;
		decoded.opcode           = opcode;
		decoded.sub_op_base      = word.r.sub_op_base;
		decoded.sub_op_ls        = word.ls.sub_op_ls;
		decoded.imm14            = word.i.imm14;
		decoded.imm24            = word.j.imm24;
		decoded.write_reg        = word.r.rt;
		decoded.select_write_reg = `CPU_WB_ALU;
		decoded.do_dm_read       = 1'b0;
		decoded.do_dm_write      = 1'b0;
		decoded.alu_src2         = 32'd0;
		decoded.link             = fetched.pc + 32'd1;

		case (opcode)
			`CPU_OP_ALU: begin
				writes_reg       = 1'b1;
				decoded.alu_src2 = rt_data;
			end
			`CPU_OP_ADDI: begin
				writes_reg       = 1'b1;
				decoded.alu_src2 = imm_sext;
			end
			`CPU_OP_ORI: begin
				writes_reg       = 1'b1;
				decoded.alu_src2 = imm_zext;
			end
			`CPU_OP_LSW: begin
				decoded.alu_src2 = imm_sext; // Word offset
				if (word.ls.sub_op_ls == `CPU_LS_LW) begin
					writes_reg                 = 1'b1;
					decoded.do_dm_read         = fetched.valid;
					decoded.select_write_reg   = `CPU_WB_MEM;
				end else if (word.ls.sub_op_ls == `CPU_LS_SW) begin
					decoded.do_dm_write = fetched.valid;
				end
			end
			`CPU_OP_JAL: begin
				writes_reg               = 1'b1;
				decoded.write_reg        = `CPU_LINK_REG;
				decoded.select_write_reg = `CPU_WB_LINK;
			end
			default: ;
		endcase

		// r0 as destination drops the write
		decoded.do_reg_write = fetched.valid && writes_reg && (decoded.write_reg != 5'd0);
	end

endmodule

// File: rtl/reg_file.sv
module reg_file (
	input  logic        clock,
	input  logic        rst,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] ra_data,
	output logic [31:0] rt_data,
	input  logic        write_en,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data
);
	logic [31:0] regs [0:31];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (write_en && write_addr != 5'd0) begin
			regs[write_addr] <= write_data;
		end
	end

	// Same-cycle write shows through to decode
	always_comb begin
		if (ra_addr == 5'd0)                          ra_data = 32'd0;
		else if (write_en && write_addr == ra_addr)   ra_data = write_data;
		else                                          ra_data = regs[ra_addr];

		if (rt_addr == 5'd0)                          rt_data = 32'd0;
		else if (write_en && write_addr == rt_addr)   rt_data = write_data;
		else                                          rt_data = regs[rt_addr];
	end

endmodule

// File: rtl/alu.sv
`include "cpu_consts.svh"

module alu (
	input  cpu_pkg::id_ex_t operation,
	output logic [31:0]     result,
	output logic            overflow
);
	import cpu_pkg::*;

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sum;
	logic [31:0] diff;
	logic        add_ovf;
	logic        sub_ovf;
	logic        is_add;
	logic        is_sub;

	assign a    = operation.ra_data;
	assign b    = operation.alu_src2;
	assign sum  = a + b;
	assign diff = a - b;

	// Signed overflow from operand and result signs
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb begin
		is_add = 1'b0;
		is_sub = 1'b0;
		result = 32'd0;
		case (operation.opcode)
			`CPU_OP_ALU: begin
				case (operation.sub_op_base)
					`CPU_SUB_ADD: begin is_add = 1'b1; result = sum; end
					`CPU_SUB_SUB: begin is_sub = 1'b1; result = diff; end
					`CPU_SUB_AND: result = a & b;
					`CPU_SUB_OR:  result = a | b;
					`CPU_SUB_XOR: result = a ^ b;
					default:      result = 32'd0;
				endcase
			end
			`CPU_OP_ADDI: begin is_add = 1'b1; result = sum; end
			`CPU_OP_ORI:  result = a | b;
			`CPU_OP_LSW:  result = sum; // Address, no overflow
			default:      result = 32'd0;
		endcase
		overflow = (is_add && add_ovf) || (is_sub && sub_ovf);
	end

endmodule

// File: rtl/regwalls.sv
module regwalls (
	input  logic             clock,
	input  logic             rst,
	input  logic             squash,

	input  cpu_pkg::if_id_t  reg1_in,
	output cpu_pkg::if_id_t  reg1_out,

	input  cpu_pkg::id_ex_t  reg2_in,
	output cpu_pkg::id_ex_t  reg2_out,

	input  cpu_pkg::ex_mem_t reg3_in,
	output cpu_pkg::ex_mem_t reg3_out,

	input  cpu_pkg::mem_wb_t reg4_in,
	output cpu_pkg::mem_wb_t reg4_out
);

	always_ff @(posedge clock) begin
		reg1_out <= reg1_in;
		reg2_out <= reg2_in;
		reg3_out <= reg3_in;
		reg4_out <= reg4_in;

		if (rst) begin
			reg1_out.valid <= 1'b0;

			reg2_out.valid        <= 1'b0;
			reg2_out.do_dm_read   <= 1'b0;
			reg2_out.do_dm_write  <= 1'b0;
			reg2_out.do_reg_write <= 1'b0;

			reg3_out.valid        <= 1'b0;
			reg3_out.do_dm_read   <= 1'b0;
			reg3_out.do_dm_write  <= 1'b0;
			reg3_out.do_reg_write <= 1'b0;

			reg4_out.do_reg_write <= 1'b0;
		end else if (squash) begin
			reg1_out.valid <= 1'b0; // Word behind a jump
		end
	end

endmodule

// File: rtl/data_mem.sv
`include "cpu_consts.svh"

module data_mem (
	input  logic             clock,
	input  cpu_pkg::ex_mem_t access,
	output logic [31:0]      read_data
);
	logic [31:0]           mem [0:(1 << `CPU_DM_AW) - 1];
	logic [`CPU_DM_AW-1:0] addr;

	// Word index, upper address bits wrap
	assign addr = access.alu_result[`CPU_DM_AW-1:0];

	always_ff @(posedge clock) begin
		if (access.do_dm_write) begin
			mem[addr] <= access.store_data;
		end
	end

	assign read_data = mem[addr];

endmodule

// File: rtl/cpu_top.sv
`include "cpu_consts.svh"

module cpu_top (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic [`CPU_IM_AW-1:0] load_addr,
	input  logic [31:0]           load_data,
	output cpu_pkg::wb_event_t    wb_event,
	output cpu_pkg::store_event_t store_event
);
	import cpu_pkg::*;

	if_id_t      reg1_in;
	if_id_t      reg1_out;
	id_ex_t      reg2_in;
	id_ex_t      reg2_out;
	ex_mem_t     reg3_in;
	ex_mem_t     reg3_out;
	mem_wb_t     reg4_in;
	mem_wb_t     reg4_out;
	logic        jump_taken;
	logic [23:0] jump_target;
	logic [4:0]  ra_addr;
	logic [4:0]  rt_addr;
	logic [31:0] ra_data;
	logic [31:0] rt_data;
	logic [31:0] alu_result;
	logic        alu_overflow;
	logic [31:0] dm_read_data;

	fetch_unit fetch_i (
		.clock(clock), .rst(rst), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .jump_taken(jump_taken), .jump_target(jump_target),
		.fetch(reg1_in)
	);

	decode_ctrl decode_i (
		.fetched(reg1_out), .ra_data(ra_data), .rt_data(rt_data), .ra_addr(ra_addr),
		.rt_addr(rt_addr), .decoded(reg2_in), .jump_taken(jump_taken),
		.jump_target(jump_target)
	);

	reg_file regs_i (
		.clock(clock), .rst(rst), .ra_addr(ra_addr), .rt_addr(rt_addr),
		.ra_data(ra_data), .rt_data(rt_data), .write_en(reg4_out.do_reg_write),
		.write_addr(reg4_out.write_reg), .write_data(reg4_out.write_reg_data)
	);

	alu alu_i (.operation(reg2_out), .result(alu_result), .overflow(alu_overflow));

	regwalls walls_i (
		.clock(clock), .rst(rst), .squash(jump_taken),
		.reg1_in(reg1_in), .reg1_out(reg1_out), .reg2_in(reg2_in), .reg2_out(reg2_out),
		.reg3_in(reg3_in), .reg3_out(reg3_out), .reg4_in(reg4_in), .reg4_out(reg4_out)
	);

	data_mem dmem_i (.clock(clock), .access(reg3_out), .read_data(dm_read_data));

	always_comb begin
		reg3_in.valid            = reg2_out.valid;
		reg3_in.alu_result       = alu_result;
		reg3_in.alu_overflow     = alu_overflow;
		reg3_in.store_data       = reg2_out.rt_data;
		reg3_in.write_reg        = reg2_out.write_reg;
		reg3_in.select_write_reg = reg2_out.select_write_reg;
		reg3_in.do_dm_read       = reg2_out.do_dm_read;
		reg3_in.do_dm_write      = reg2_out.do_dm_write;
		reg3_in.do_reg_write     = reg2_out.do_reg_write;
		reg3_in.link             = reg2_out.link;
	end

	// Write-back source mux
	always_comb begin
		reg4_in.write_reg    = reg3_out.write_reg;
		reg4_in.do_reg_write = reg3_out.do_reg_write;
		reg4_in.overflow     = reg3_out.alu_overflow;
		case (reg3_out.select_write_reg)
			`CPU_WB_MEM:  reg4_in.write_reg_data = reg3_out.do_dm_read ? dm_read_data : 32'd0;
			`CPU_WB_LINK: reg4_in.write_reg_data = reg3_out.link;
			default:      reg4_in.write_reg_data = reg3_out.alu_result;
		endcase
	end

	always_comb begin
		wb_event.valid    = reg4_out.do_reg_write;
		wb_event.reg_num  = reg4_out.write_reg;
		wb_event.data     = reg4_out.write_reg_data;
		wb_event.overflow = reg4_out.overflow;

		store_event.valid   = reg3_out.do_dm_write; // Same cycle as the memory write
		store_event.address = reg3_out.alu_result;
		store_event.data    = reg3_out.store_data;
	end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
	output logic clock,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clock);
		#1 rst = 1'b0;
	end

endmodule

// File: tests/cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	logic                  clock;
	logic                  gen_rst;
	logic                  loading;
	logic                  load_en;
	logic [`CPU_IM_AW-1:0] load_addr;
	logic [31:0]           load_data;
	wb_event_t             wb_event;
	store_event_t          store_event;

	logic [31:0] prog [0:255];
	int          n;
	int          last_wr [32];
	int          seed;
	logic [37:0] wb_q [$];    // {reg, data, overflow}
	logic [63:0] st_q [$];    // {address, data}
	logic [5:0]  stored_hi [$];
	int          value_errs;
	int          other_errs;
	int          cycles;
	int          limit;
	bit          timed_out;

	tb_clock clk_i (.clock(clock), .rst(gen_rst));

	cpu_top dut_i (
		.clock(clock), .rst(gen_rst || loading), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .wb_event(wb_event), .store_event(store_event)
	);

	function automatic logic [31:0] enc_r(logic [4:0] sub, logic [4:0] rt, logic [4:0] ra,
			logic [4:0] rb);
		return {1'b0, `CPU_OP_ALU, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
			logic [13:0] imm);
		return {1'b0, op, rt, ra, 1'b0, imm};
	endfunction

	// Offset low byte is the ls code itself
	function automatic logic [31:0] enc_ls(logic [7:0] ls, logic [4:0] rt, logic [4:0] ra,
			logic [5:0] hi);
		return {1'b0, `CPU_OP_LSW, rt, ra, 1'b0, hi, ls};
	endfunction

	function automatic logic [31:0] enc_j(logic [5:0] op, int target);
		return {1'b0, op, 1'b0, target[23:0]};
	endfunction

	task automatic put(input logic [31:0] w);
		prog[n] = w;
		n++;
	endtask

	// Pads with NOPs so sources are three or more words behind their producer
	task automatic emit(input logic [31:0] w, input int dst, input int a, input int b);
		if (a != 0) while (n - last_wr[a] < 3) put(enc_i(`CPU_OP_ADDI, 0, 0, 0));
		if (b != 0) while (n - last_wr[b] < 3) put(enc_i(`CPU_OP_ADDI, 0, 0, 0));
		put(w);
		if (dst != 0) last_wr[dst] = n - 1;
	endtask

	function automatic int rnd(int m);
		return $unsigned($random(seed)) % m;
	endfunction

	// ISA level model of the program
	function automatic void run_model();
		logic [31:0] r [32];
		logic [31:0] dm [256];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		longint      s;
		logic        ovf;
		logic        wr;
		int          dst;
		int          steps;
		for (int i = 0; i < 32; i++) r[i] = 32'd0;
		pc = 0;
		for (steps = 0; steps < 1000; steps++) begin
			w = prog[pc[7:0]];
			a = r[w[19:15]];
			dst = w[24:20];
			ovf = 1'b0;
			wr = 1'b0;
			res = 32'd0;
			s = 0;
			if (w[30:25] == `CPU_OP_J && w[23:0] == pc[23:0]) break; // Halt loop
			case (w[30:25])
				`CPU_OP_ALU: begin
					b = r[w[14:10]];
					wr = 1'b1;
					case (w[4:0])
						`CPU_SUB_ADD: s = longint'($signed(a)) + longint'($signed(b));
						`CPU_SUB_SUB: s = longint'($signed(a)) - longint'($signed(b));
						`CPU_SUB_AND: res = a & b;
						`CPU_SUB_OR:  res = a | b;
						default:      res = a ^ b;
					endcase
					if (w[4:0] == `CPU_SUB_ADD || w[4:0] == `CPU_SUB_SUB) begin
						res = s[31:0];
						ovf = (s > 64'sh7fffffff) || (s < -64'sh80000000);
					end
				end
				`CPU_OP_ADDI: begin
					s = longint'($signed(a)) + longint'($signed(w[13:0]));
					res = s[31:0];
					ovf = (s > 64'sh7fffffff) || (s < -64'sh80000000);
					wr = 1'b1;
				end
				`CPU_OP_ORI: begin
					res = a | {18'd0, w[13:0]};
					wr = 1'b1;
				end
				`CPU_OP_LSW: begin
					addr = a + {{18{w[13]}}, w[13:0]};
					if (w[7:0] == `CPU_LS_LW) begin
						res = dm[addr[7:0]];
						wr = 1'b1;
					end else begin
						dm[addr[7:0]] = r[w[24:20]];
						st_q.push_back({addr, r[w[24:20]]});
					end
				end
				`CPU_OP_JAL: begin
					res = pc + 1;
					dst = 31;
					wr = 1'b1;
				end
				default: ;
			endcase
			if (wr && dst != 0) begin
				r[dst] = res;
				wb_q.push_back({dst[4:0], res, ovf});
			end
			if (w[30:25] == `CPU_OP_J || w[30:25] == `CPU_OP_JAL) pc = {8'd0, w[23:0]};
			else pc = pc + 1;
		end
	endfunction

	task automatic build_program();
		logic [4:0] subs [5];
		int         k;
		int         d;
		int         a;
		int         b;
		logic [5:0] hi;
		subs = '{`CPU_SUB_ADD, `CPU_SUB_SUB, `CPU_SUB_AND, `CPU_SUB_OR, `CPU_SUB_XOR};
		emit(enc_i(`CPU_OP_ADDI, 1, 0, rnd(16384)), 1, 0, 0);
		emit(enc_i(`CPU_OP_ORI, 2, 0, rnd(16384)), 2, 0, 0);
		emit(enc_i(`CPU_OP_ADDI, 3, 1, rnd(16384)), 3, 1, 0);
		for (int i = 0; i < 5; i++) emit(enc_r(subs[i], 4 + i, 3, 2), 4 + i, 3, 2);
		// Doubling chains run into signed overflow
		emit(enc_i(`CPU_OP_ORI, 9, 0, 14'h3fff), 9, 0, 0);
		emit(enc_i(`CPU_OP_ORI, 11, 0, rnd(16384)), 11, 0, 0);
		for (int i = 0; i < 20; i++) emit(enc_r(`CPU_SUB_ADD, 9, 9, 9), 9, 9, 0);
		emit(enc_r(`CPU_SUB_SUB, 10, 0, 9), 10, 9, 0);
		for (int i = 0; i < 3; i++) emit(enc_r(`CPU_SUB_SUB, 10, 10, 9), 10, 10, 9);
		for (int i = 0; i < 19; i++) emit(enc_r(`CPU_SUB_ADD, 11, 11, 11), 11, 11, 0);
		emit(enc_r(`CPU_SUB_AND, 12, 9, 10), 12, 9, 10);
		emit(enc_r(`CPU_SUB_XOR, 13, 11, 10), 13, 11, 10);
		emit(enc_r(`CPU_SUB_OR, 14, 9, 11), 14, 9, 11);
		// SW base + 8 meets LW at the same word
		for (int i = 0; i < 3; i++) begin
			hi = rnd(64);
			emit(enc_i(`CPU_OP_ADDI, 15, 0, rnd(4096)), 15, 0, 0);
			emit(enc_i(`CPU_OP_ADDI, 16, 15, 8), 16, 15, 0);
			emit(enc_ls(`CPU_LS_SW, 4 + i, 15, hi), 0, 15, 4 + i);
			emit(enc_ls(`CPU_LS_LW, 17, 16, hi), 17, 16, 0);
		end
		put(enc_j(`CPU_OP_J, n + 2));
		put(enc_i(`CPU_OP_ADDI, 5, 0, 14'h123)); // Squashed
		put(enc_j(`CPU_OP_JAL, n + 2));
		last_wr[31] = n - 1;
		put(enc_i(`CPU_OP_ORI, 6, 0, 14'h55)); // Squashed
		emit(enc_r(`CPU_SUB_ADD, 0, 1, 2), 0, 1, 2);
		emit(enc_r(`CPU_SUB_ADD, 18, 31, 1), 18, 31, 1);
		emit(enc_i(`CPU_OP_ADDI, 20, 0, 8), 20, 0, 0);
		for (int i = 0; i < 40; i++) begin
			k = rnd(8);
			d = rnd(20);
			a = rnd(21);
			b = rnd(21);
			if (k < 5) emit(enc_r(subs[k], d, a, b), d, a, b);
			else if (k == 5) emit(enc_i(`CPU_OP_ADDI, d, a, rnd(16384)), d, a, 0);
			else if (k == 6) emit(enc_i(`CPU_OP_ORI, d, a, rnd(16384)), d, a, 0);
			else if (stored_hi.size() > 0 && rnd(2) == 1) begin
				emit(enc_ls(`CPU_LS_LW, d, 20, stored_hi[rnd(stored_hi.size())]), d, 20, 0);
			end else begin
				hi = rnd(64);
				stored_hi.push_back(hi);
				emit(enc_ls(`CPU_LS_SW, b, 0, hi), 0, 0, b);
			end
		end
		put(enc_j(`CPU_OP_J, n)); // Halt on itself
	endtask

	always @(posedge clock) begin
		if (!(gen_rst || loading)) cycles <= cycles + 1;
	end

	always @(negedge clock) begin
		logic [37:0] we;
		logic [63:0] se;
		if (loading && load_en) begin
			if (wb_event.valid === 1'b1 || store_event.valid === 1'b1) begin
				other_errs++;
				$display("Event seen while the program was still loading at %0t", $time);
			end
		end else if (!(gen_rst || loading)) begin
			if (wb_event.valid !== 1'b0) begin
				if (wb_q.size() == 0) begin
					other_errs++;
					$display("Unexpected write-back to r%0d at %0t", wb_event.reg_num, $time);
				end else begin
					we = wb_q.pop_front();
					if (wb_event.reg_num !== we[37:33] || wb_event.data !== we[32:1] ||
							wb_event.overflow !== we[0]) begin
						value_errs++;
						$display("** Error at %0t: wb r%0d=%h ovf %b, expected r%0d=%h ovf %b",
							$time, wb_event.reg_num, wb_event.data, wb_event.overflow,
							we[37:33], we[32:1], we[0]);
					end
				end
			end
			if (store_event.valid !== 1'b0) begin
				if (st_q.size() == 0) begin
					other_errs++;
					$display("Unexpected store to %h at %0t", store_event.address, $time);
				end else begin
					se = st_q.pop_front();
					if (store_event.address !== se[63:32] || store_event.data !== se[31:0]) begin
						value_errs++;
						$display("** Error at %0t: store [%h]=%h, expected [%h]=%h", $time,
							store_event.address, store_event.data, se[63:32], se[31:0]);
					end
				end
			end
		end
	end

	initial begin
		seed = 32'h1057e4ba;
		load_en = 1'b0;
		load_addr = '0;
		load_data = 32'd0;
		loading = 1'b1;
		n = 0;
		value_errs = 0;
		other_errs = 0;
		cycles = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 32; i++) last_wr[i] = -10;
		build_program();
		run_model();
		limit = 4 * n + 50;
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			#1;
			load_en = 1'b1;
			load_addr = i;
			load_data = prog[i];
		end
		@(posedge clock);
		#1;
		load_en = 1'b0;
		wait (gen_rst == 1'b0);
		loading = 1'b0;
		while ((wb_q.size() != 0 || st_q.size() != 0) && cycles < limit) @(negedge clock);
		timed_out = (cycles >= limit);
		repeat (10) @(negedge clock); // Catch late spurious events
		if (timed_out) begin
			other_errs++;
			$display("Timeout after %0d cycles with %0d write-backs and %0d stores missing",
				cycles, wb_q.size(), st_q.size());
		end
		$display("Summary: %0d value errors, %0d other errors, %0d words",
			value_errs, other_errs, n);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_ctrl.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/regwalls.sv
rtl/data_mem.sv
rtl/cpu_top.sv
tests/tb_clock.sv
tests/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
